// File: design/dac_cfg.svh
// DAC controller configuration
// default word, version, SPI clock divide and startup behavior

`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// word sent after reset, also the reset value of the DAC register
`define DAC_DEFAULT 16'd100

// read-only version word at register 0
`define DAC_MODULE_VERSION 16'd1

// clk cycles per sclk half period
`define DAC_SPI_HALF_PERIOD 2

// 1: push the default word to the DAC once after reset
`define DAC_SET_DEFAULT_ON_RESET 1'b1

`endif

// File: design/mmi_pkg.sv
// register bus types
// opcodes, register map and data word of the host bus

package mmi_pkg;

    // bus operation
    typedef enum logic {
        MMI_READ  = 1'b0,
        MMI_WRITE = 1'b1
    } mmi_op_t;

    // register map, unlisted addresses read as zero
    typedef enum logic [14:0] {
        ADDR_MODULE_VERSION = 15'd0,
        ADDR_DAC_REG        = 15'd1,
        ADDR_EN_MMI_CTRL    = 15'd2
    } mmi_addr_t;

    typedef logic [15:0] mmi_data_t;

endpackage

// File: design/spi_pkg.sv
// DAC frame and SPI shifter types

package spi_pkg;

    // AD5601 frame, MSB first on the wire
    typedef struct packed {
        logic [1:0] pd_mode;
        logic [7:0] code;
        logic [5:0] rsvd;
    } dac_word_t;

    // shifter states
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SETUP,
        SPI_SHIFT,
        SPI_DONE
    } spi_state_t;

endpackage

// File: design/dac_reg_bank.sv
// DAC register bank
// host register file, gain merge and producer side of the command handshake

`timescale 1ns/1ps

`include "dac_cfg.svh"

module dac_reg_bank (
    input  logic                clk,
    input  logic                rst,
    // host bus
    input  logic                mmi_req,
    input  mmi_pkg::mmi_op_t    mmi_op,
    input  mmi_pkg::mmi_addr_t  mmi_addr,
    input  mmi_pkg::mmi_data_t  mmi_wdata,
    output logic                mmi_ack,
    output mmi_pkg::mmi_data_t  mmi_rdata,
    // local gain source
    input  logic                en_mmi_ctrl,
    input  logic [7:0]          gain_code,
    input  logic                gain_valid,
    // command path to the buffer
    output logic                cmd_req,
    output spi_pkg::dac_word_t  cmd_word,
    input  logic                cmd_ack
);

    import mmi_pkg::*;
    import spi_pkg::*;

    dac_word_t dac_reg;
    dac_word_t dac_next;
    logic      bus_start;
    logic      wr_hit;
    logic      gain_hit;
    logic      upd;
    logic      pend;
    logic      launch;

    ////////////////////////////////////////////////////////////
    // host bus decode
    ////////////////////////////////////////////////////////////

    // first cycle of a bus transaction
    assign bus_start = mmi_req && !mmi_ack;

    // host writes only reach the DAC register in host mode
    assign wr_hit   = bus_start && (mmi_op == MMI_WRITE) && (mmi_addr == ADDR_DAC_REG)
                      && en_mmi_ctrl;
    assign gain_hit = gain_valid && !en_mmi_ctrl;
    assign upd      = wr_hit || gain_hit;

    // ack follows req by one cycle in both directions
    always_ff @(posedge clk) begin
        if (rst) begin
            mmi_ack <= 1'b0;
        end else begin
            mmi_ack <= mmi_req;
        end
    end

    // read data is captured with the ack
    always_ff @(posedge clk) begin
        if (bus_start) begin
            case (mmi_addr)
                ADDR_MODULE_VERSION: mmi_rdata <= `DAC_MODULE_VERSION;
                ADDR_DAC_REG:        mmi_rdata <= dac_reg;
                ADDR_EN_MMI_CTRL:    mmi_rdata <= {{15{1'b0}}, en_mmi_ctrl};
                default:             mmi_rdata <= '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // DAC register
    ////////////////////////////////////////////////////////////

    // gain only replaces the code field and leaves mode and reserved bits
    always_comb begin
        dac_next = dac_reg;
        if (wr_hit) begin
            dac_next = mmi_wdata;
        end else if (gain_hit) begin
            dac_next.code = gain_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dac_reg <= `DAC_DEFAULT;
        end else begin
            dac_reg <= dac_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // command producer
    ////////////////////////////////////////////////////////////

    // new request only once the previous four-phase cycle is closed
    assign launch = !cmd_req && !cmd_ack && (upd || pend);

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_req <= 1'b0;
            pend    <= `DAC_SET_DEFAULT_ON_RESET;
        end else begin
            if (cmd_req && cmd_ack) begin
                cmd_req <= 1'b0;
            end
            if (launch) begin
                cmd_req <= 1'b1;
                pend    <= 1'b0;
            end else if (upd) begin
                // held until the handshake closes so that the latest value is sent
                pend    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_word <= dac_next;
        end
    end

    // the host must still hold req when ack comes up
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(mmi_ack) |-> mmi_req
    );

endmodule

// File: design/dac_cmd_buffer.sv
// DAC command buffer
// one-entry coalescing store between the register bank and the SPI shifter

`timescale 1ns/1ps

module dac_cmd_buffer (
    input  logic               clk,
    input  logic               rst,
    // from the register bank
    input  logic               cmd_req,
    input  spi_pkg::dac_word_t cmd_word,
    output logic               cmd_ack,
    // to the SPI shifter
    output logic               frm_req,
    output spi_pkg::dac_word_t frm_word,
    input  logic               frm_ack
);

    import spi_pkg::*;

    dac_word_t pend_word;
    logic      full;
    logic      accept;
    logic      launch;

    // every command is taken, a newer word overwrites the entry
    assign accept = cmd_req && !cmd_ack;

    // offer the entry once the frame handshake is back to idle
    assign launch = full && !frm_req && !frm_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ack <= 1'b0;
            frm_req <= 1'b0;
            full    <= 1'b0;
        end else begin
            cmd_ack <= cmd_req;
            if (frm_req && frm_ack) begin
                frm_req <= 1'b0;
            end
            if (launch) begin
                frm_req <= 1'b1;
                full    <= 1'b0;
            end
            // an arriving word wins over the launch clearing the flag
            if (accept) begin
                full    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_word <= cmd_word;
        end
        if (launch) begin
            frm_word  <= pend_word;
        end
    end

    // later commands land in the entry, never in the offered word
    a_frm_word_stable: assert property (
        @(posedge clk) disable iff (rst)
        frm_req && $past(frm_req) |-> $stable(frm_word)
    );

endmodule

// File: design/dac_spi_shifter.sv
// DAC SPI shifter
// sends one 16-bit word per frame on sclk, sync_n and din

`timescale 1ns/1ps

`include "dac_cfg.svh"

module dac_spi_shifter (
    input  logic               clk,
    input  logic               rst,
    // frame handshake from the buffer
    input  logic               frm_req,
    input  spi_pkg::dac_word_t frm_word,
    output logic               frm_ack,
    // DAC pins
    output logic               sclk,
    output logic               sync_n,
    output logic               din,
    output logic               dac_updated
);

    import spi_pkg::*;

    localparam int DIV_W = $clog2(2 * `DAC_SPI_HALF_PERIOD);
    localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(`DAC_SPI_HALF_PERIOD);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(2 * `DAC_SPI_HALF_PERIOD - 1);

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    logic [15:0]      shift_q;
    logic             take;

    // latch a new word only from idle on a fresh request
    assign take = (state == SPI_IDLE) && frm_req && !frm_ack;

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SPI_IDLE;
            frm_ack     <= 1'b0;
            sclk        <= 1'b0;
            sync_n      <= 1'b1;
            din         <= 1'b0;
            dac_updated <= 1'b0;
            div_cnt     <= '0;
            bit_cnt     <= '0;
        end else begin
            dac_updated <= 1'b0;
            if (!frm_req) begin
                frm_ack <= 1'b0;
            end
            case (state)
                SPI_IDLE: begin
                    if (take) begin
                        frm_ack <= 1'b1;
                        state   <= SPI_SETUP;
                    end
                end
                SPI_SETUP: begin
                    sync_n  <= 1'b0;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= SPI_SHIFT;
                end
                SPI_SHIFT: begin
                    // din moves on the rising sclk edge, DAC samples on the fall
                    if (div_cnt == '0) begin
                        sclk <= 1'b1;
                        din  <= shift_q[15];
                    end else if (div_cnt == DIV_HALF) begin
                        sclk <= 1'b0;
                    end
                    if (div_cnt == DIV_LAST) begin
                        div_cnt <= '0;
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd15) begin
                            sync_n      <= 1'b1;
                            dac_updated <= 1'b1;
                            state       <= SPI_DONE;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                SPI_DONE: begin
                    state <= SPI_IDLE;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // MSB first, shifted out as each bit goes onto din
    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= frm_word;
        end else if (state == SPI_SHIFT && div_cnt == '0) begin
            shift_q <= {shift_q[14:0], 1'b0};
        end
    end

    // the frame stays selected for the whole shift phase
    a_sync_low_in_shift: assert property (
        @(posedge clk) disable iff (rst)
        state == SPI_SHIFT |-> !sync_n
    );

endmodule

// File: design/dac_ctrl_top.sv
// DAC controller top level
// register bank, command buffer and SPI shifter in a chain

`timescale 1ns/1ps

module dac_ctrl_top (
    input  logic               clk,
    input  logic               rst,
    // host bus
    input  logic               mmi_req,
    input  mmi_pkg::mmi_op_t   mmi_op,
    input  mmi_pkg::mmi_addr_t mmi_addr,
    input  mmi_pkg::mmi_data_t mmi_wdata,
    output logic               mmi_ack,
    output mmi_pkg::mmi_data_t mmi_rdata,
    // mode and local gain source
    input  logic               en_mmi_ctrl,
    input  logic [7:0]         gain_code,
    input  logic               gain_valid,
    // DAC pins
    output logic               sclk,
    output logic               sync_n,
    output logic               din,
    output logic               dac_updated
);

    import spi_pkg::*;

    // bank to buffer
    logic      cmd_req;
    logic      cmd_ack;
    dac_word_t cmd_word;

    // buffer to shifter
    logic      frm_req;
    logic      frm_ack;
    dac_word_t frm_word;

    dac_reg_bank dac_reg_bank_i (
        .clk         (clk),
        .rst         (rst),
        .mmi_req     (mmi_req),
        .mmi_op      (mmi_op),
        .mmi_addr    (mmi_addr),
        .mmi_wdata   (mmi_wdata),
        .mmi_ack     (mmi_ack),
        .mmi_rdata   (mmi_rdata),
        .en_mmi_ctrl (en_mmi_ctrl),
        .gain_code   (gain_code),
        .gain_valid  (gain_valid),
        .cmd_req     (cmd_req),
        .cmd_word    (cmd_word),
        .cmd_ack     (cmd_ack)
    );

    dac_cmd_buffer dac_cmd_buffer_i (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_word (cmd_word),
        .cmd_ack  (cmd_ack),
        .frm_req  (frm_req),
        .frm_word (frm_word),
        .frm_ack  (frm_ack)
    );

    dac_spi_shifter dac_spi_shifter_i (
        .clk         (clk),
        .rst         (rst),
        .frm_req     (frm_req),
        .frm_word    (frm_word),
        .frm_ack     (frm_ack),
        .sclk        (sclk),
        .sync_n      (sync_n),
        .din         (din),
        .dac_updated (dac_updated)
    );

endmodule

// File: testbench/dac_ctrl_tb.sv
// DAC controller testbench
// replays the test data file on the host bus and checks the captured SPI frames

`timescale 1ns/1ps

module dac_ctrl_tb;

    import mmi_pkg::*;

    localparam int TIMEOUT  = 1000;
    localparam int IDLE_RUN = 16;

    logic       clk = 1'b0;
    logic       rst;
    logic       mmi_req;
    mmi_op_t    mmi_op;
    mmi_addr_t  mmi_addr;
    mmi_data_t  mmi_wdata;
    logic       mmi_ack;
    mmi_data_t  mmi_rdata;
    logic       en_mmi_ctrl;
    logic [7:0] gain_code;
    logic       gain_valid;
    logic       sclk;
    logic       sync_n;
    logic       din;
    logic       dac_updated;

    int err_cnt   = 0;
    int other_cnt = 0;
    int cap_errs  = 0;
    bit aborted   = 1'b0;

    // frames and dac_updated pulses seen on the DAC pins
    logic [15:0] frames[$];
    int          upd_cnt = 0;
    int          frm_rd  = 0;
    // host writes to the DAC register since the last idle check
    logic [15:0] written[$];

    logic        sclk_q   = 1'b0;
    logic        upd_q    = 1'b0;
    logic [15:0] cap_word = '0;
    int          cap_cnt  = 0;

    dac_ctrl_top dac_ctrl_top_i (
        .clk         (clk),
        .rst         (rst),
        .mmi_req     (mmi_req),
        .mmi_op      (mmi_op),
        .mmi_addr    (mmi_addr),
        .mmi_wdata   (mmi_wdata),
        .mmi_ack     (mmi_ack),
        .mmi_rdata   (mmi_rdata),
        .en_mmi_ctrl (en_mmi_ctrl),
        .gain_code   (gain_code),
        .gain_valid  (gain_valid),
        .sclk        (sclk),
        .sync_n      (sync_n),
        .din         (din),
        .dac_updated (dac_updated)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // SPI frame capture
    ////////////////////////////////////////////////////////////

    // a falling sclk shows up as sclk_q high and sclk low, din is still the bit
    always @(posedge clk) begin
        if (rst) begin
            sclk_q  = 1'b0;
            upd_q   = 1'b0;
            cap_cnt = 0;
        end else begin
            if (dac_updated) begin
                upd_cnt++;
                if (upd_q) begin
                    $display("dac_updated stayed high for more than one cycle");
                    cap_errs++;
                end
            end
            upd_q = dac_updated;
            if (sync_n) begin
                if (cap_cnt != 0) begin
                    $display("frame ended after %0d bits", cap_cnt);
                    cap_errs++;
                end
                cap_cnt = 0;
            end else if (sclk_q && !sclk) begin
                cap_word = {cap_word[14:0], din};
                cap_cnt++;
                if (cap_cnt == 16) begin
                    frames.push_back(cap_word);
                    cap_cnt = 0;
                end
            end
            sclk_q = sclk;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks and waits
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic fail_other(input string what);
        $display("%s", what);
        other_cnt++;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (mmi_ack !== level && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (mmi_ack !== level) begin
            fail_other($sformatf("timeout waiting for mmi_ack to go %0d", level));
            aborted = 1'b1;
        end
    endtask

    // idle means sync_n has stayed high for a whole run of cycles
    task automatic wait_idle();
        int n;
        int run;
        n = 0;
        run = 0;
        while (run < IDLE_RUN && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            if (sync_n === 1'b1) begin
                run++;
            end else begin
                run = 0;
            end
        end
        if (run < IDLE_RUN) begin
            fail_other("timeout waiting for the SPI side to go idle");
            aborted = 1'b1;
        end
    endtask

    task automatic bus_cycle(input mmi_op_t op, input logic [31:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        @(posedge clk);
        mmi_req   <= 1'b1;
        mmi_op    <= op;
        mmi_addr  <= mmi_addr_t'(addr[14:0]);
        mmi_wdata <= wdata;
        wait_ack(1'b1);
        rdata = mmi_rdata;
        mmi_req <= 1'b0;
        if (!aborted) begin
            wait_ack(1'b0);
        end
    endtask

    task automatic gain_strobe(input logic [7:0] code);
        @(posedge clk);
        gain_code  <= code;
        gain_valid <= 1'b1;
        @(posedge clk);
        gain_valid <= 1'b0;
    endtask

    task automatic expect_frame(input string name, input logic [15:0] exp);
        int n;
        n = 0;
        while (frm_rd >= frames.size() && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (frm_rd >= frames.size()) begin
            fail_other($sformatf("timeout waiting for a frame (%s)", name));
            aborted = 1'b1;
        end else begin
            check(name, exp, frames[frm_rd]);
            frm_rd++;
        end
    endtask

    // coalesced writes: every frame must be a written value, the last one wins
    task automatic expect_burst(input string name, input logic [15:0] exp);
        logic [15:0] last;
        bit          found;
        last = '0;
        wait_idle();
        if (!aborted && frm_rd >= frames.size()) begin
            fail_other($sformatf("no frame after the write burst (%s)", name));
        end else if (!aborted) begin
            while (frm_rd < frames.size()) begin
                last  = frames[frm_rd];
                found = 1'b0;
                foreach (written[i]) begin
                    if (written[i] === last) begin
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    fail_other($sformatf("frame %h was never written (%s)", last, name));
                end
                frm_rd++;
            end
            check(name, exp, last);
        end
        written.delete();
    endtask

    task automatic check_idle(input string name);
        wait_idle();
        if (!aborted) begin
            while (frm_rd < frames.size()) begin
                fail_other($sformatf("unexpected frame %h before %s", frames[frm_rd], name));
                frm_rd++;
            end
            check({"dac_updated count, ", name}, 16'(frames.size()), 16'(upd_cnt));
        end
        written.delete();
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] arg,
                          input logic [31:0] data, input int line_no);
        logic [15:0] rd;
        string       name;
        name = $sformatf("%c %0h %0h (line %0d)", op, arg, data, line_no);
        case (op)
            "W": begin
                bus_cycle(MMI_WRITE, arg, data[15:0], rd);
                if (arg == 32'd1 && en_mmi_ctrl) begin
                    written.push_back(data[15:0]);
                end
            end
            "R": begin
                bus_cycle(MMI_READ, arg, 16'h0000, rd);
                if (!aborted) begin
                    check(name, data[15:0], rd);
                end
            end
            "G": gain_strobe(arg[7:0]);
            "E": begin
                @(posedge clk);
                en_mmi_ctrl <= data[0];
            end
            "F": begin
                if (arg == 32'd0) begin
                    expect_frame(name, data[15:0]);
                end else begin
                    expect_burst(name, data[15:0]);
                end
            end
            "I": check_idle(name);
            default: fail_other($sformatf("unknown operation on line %0d", line_no));
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [7:0]  op;
        logic [31:0] arg;
        logic [31:0] data;
        rst         = 1'b1;
        mmi_req     = 1'b0;
        mmi_op      = MMI_READ;
        mmi_addr    = ADDR_MODULE_VERSION;
        mmi_wdata   = '0;
        en_mmi_ctrl = 1'b1;
        gain_code   = '0;
        gain_valid  = 1'b0;
        line_no     = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("testbench/dac_ctrl_testdata.txt", "r");
        if (fd == 0) begin
            fail_other("cannot open testbench/dac_ctrl_testdata.txt");
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                line_no++;
                // blank lines and comment lines carry no operation
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h", op, arg, data);
                    if (n == 3) begin
                        run_op(op, arg, data, line_no);
                    end else begin
                        fail_other($sformatf("malformed test data on line %0d", line_no));
                    end
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d other failures", err_cnt, other_cnt + cap_errs);
        if (err_cnt == 0 && other_cnt == 0 && cap_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: testbench/dac_ctrl_testdata.txt
# columns: op, address or gain code, data or expected value, all hex
# op: W write, R read, G gain strobe, E mode, F frame (address 1 ends a burst), I idle
F 0 0064
R 1 0064
R 0 0001
R 2 0001
R 3 0000
R 7fff 0000
I 0 0000
W 1 c5a3
F 0 c5a3
R 1 c5a3
I 0 0000
W 1 1234
F 0 1234
I 0 0000
W 1 ffc0
F 0 ffc0
W 0 beef
W 2 0000
W 5 beef
I 0 0000
R 0 0001
R 1 ffc0
R 2 0001
R 5 0000
E 0 0000
R 2 0000
W 1 0000
I 0 0000
R 1 ffc0
G 5a 0000
F 0 d680
G a5 0000
F 0 e940
R 1 e940
I 0 0000
E 0 0001
W 1 1111
W 1 2222
W 1 3333
W 1 4444
F 1 4444
R 1 4444
I 0 0000

// File: files.f
+incdir+design
design/mmi_pkg.sv
design/spi_pkg.sv
design/dac_reg_bank.sv
design/dac_cmd_buffer.sv
design/dac_spi_shifter.sv
design/dac_ctrl_top.sv
testbench/dac_ctrl_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = dac_ctrl_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
TESTDATA  = testbench/dac_ctrl_testdata.txt
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(TESTDATA)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'PASS: all tests' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
